// ==== dv/decodeStage_props.sv ====
/*
 * Decode stage assertions
 * reset, flush and freeze behavior of the ID/EX register
 */
`timescale 1ns/1ps

module decodeStage_props (
	input logic             CLK,
	input logic             RESET,
	input logic             freeze,
	input logic             flush,
	input decodePkg::idEx_t idEx,
	input decodePkg::word_t nextPc
);
	import decodePkg::*;

	logic sinceReset; // no loading edge since reset

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET)
			sinceReset <= 1'b1;
		else if (!freeze && !flush)
			sinceReset <= 1'b0;
	end

	// --------------------------------------------------
	// properties
	// --------------------------------------------------
	flushClears: assert property (@(posedge CLK) disable iff (!RESET)
		flush |=> (idEx.ctrl == ctrl_t'('0) && !idEx.doWriteback))
		else $error("flush left control fields or doWriteback set");

	freezeHolds: assert property (@(posedge CLK) disable iff (!RESET)
		(freeze && !flush) |=> ($stable(idEx) && $stable(nextPc)))
		else $error("outputs changed under freeze");

	resetZero: assert property (@(posedge CLK) disable iff (!RESET)
		sinceReset |-> (idEx == '0 && nextPc == '0))
		else $error("outputs not zero before the first load after reset");

endmodule

bind idExRegister decodeStage_props u_decodeStageProps (.*);

// ==== dv/decodeStage_tb.sv ====
/*
 * Decode stage testbench
 * replays dv/decode_input.txt through the DUT and compares each result
 */
`timescale 1ns/1ps

module decodeStage_tb;
	import decodePkg::*;

	localparam int maxCycles = 500; // bound on the vector loop

	logic   CLK;
	logic   RESET;
	word_t  instr;
	word_t  pcNext;
	logic   freeze;
	logic   flush;
	wbReq_t wb;
	idEx_t  idEx;
	word_t  nextPc;

	decodeStage u_decodeStage (
		.CLK    (CLK),
		.RESET  (RESET),
		.instr  (instr),
		.pcNext (pcNext),
		.freeze (freeze),
		.flush  (flush),
		.wb     (wb),
		.idEx   (idEx),
		.nextPc (nextPc)
	);

	always #20 CLK = ~CLK;

	// --------------------------------------------------
	// failure reporting and compares
	// --------------------------------------------------
	task automatic stopWithFailure();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkWord(input string test, input string field,
			input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("FAILED %s %s expected %h actual %h", test, field, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkReg(input string test, input string field,
			input regAddr_t expected, input regAddr_t actual);
		if (actual !== expected) begin
			$display("FAILED %s %s expected %0d actual %0d", test, field, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkAluOp(input string test, input aluOp_t expected, input aluOp_t actual);
		if (actual !== expected) begin
			$display("FAILED %s aluOp expected %h actual %h", test, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic checkBit(input string test, input string field,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s %s expected %b actual %b", test, field, expected, actual);
			stopWithFailure();
		end
	endtask

	// --------------------------------------------------
	// vector replay
	// --------------------------------------------------
	initial begin
		int         fd;
		int         cycles;
		int         fields;
		logic       finished;
		string      line;
		string      testName;
		logic       wbEn;
		regAddr_t   wbAddr;
		word_t      wbData;
		word_t      expInstr;
		word_t      expPc;
		logic       expFreeze;
		logic       expFlush;
		logic [5:0] expAluOp;
		regAddr_t   expDest;
		word_t      expOpA;
		word_t      expOpB;
		logic       expTaken;
		logic       expWb;
		word_t      expNextPc;

		CLK    = 1'b0;
		RESET  = 1'b0;
		instr  = '0;
		pcNext = '0;
		freeze = 1'b1; // nothing loads until the first decode line
		flush  = 1'b0;
		wb     = '0;

		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;
		checkBit("reset", "idEx clear", 1'b1, idEx == '0);
		checkWord("reset", "nextPc", '0, nextPc);

		fd = $fopen("dv/decode_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file dv/decode_input.txt");
			stopWithFailure();
		end

		cycles = 0;
		while (!$feof(fd) && cycles < maxCycles) begin
			cycles++;
			if ($fgets(line, fd) == 0)
				continue;
			if (line.len() < 2 || line[0] == "#")
				continue; // blank or column notes
			@(negedge CLK);
			if (line[0] == "W") begin
				fields = $sscanf(line.substr(2, line.len() - 1), "%h %h %h",
					wbEn, wbAddr, wbData);
				if (fields != 3) begin
					$display("malformed write line in the vector file: %s", line);
					stopWithFailure();
				end
				wb.enable = wbEn;
				wb.addr   = wbAddr;
				wb.data   = wbData;
				freeze    = 1'b1; // pipeline holds while the register file fills
				flush     = 1'b0;
				@(posedge CLK);
			end else if (line[0] == "D") begin
				fields = $sscanf(line.substr(2, line.len() - 1),
					"%s %h %h %h %h %h %h %h %h %h %h %h",
					testName, expInstr, expPc, expFreeze, expFlush, expAluOp,
					expDest, expOpA, expOpB, expTaken, expWb, expNextPc);
				if (fields != 12) begin
					$display("malformed decode line in the vector file: %s", line);
					stopWithFailure();
				end
				wb.enable = 1'b0;
				instr     = expInstr;
				pcNext    = expPc;
				freeze    = expFreeze;
				flush     = expFlush;
				@(posedge CLK);
				#1; // past the register update
				checkAluOp(testName, aluOp_t'(expAluOp), idEx.ctrl.aluOp);
				checkReg(testName, "destAddr", expDest, idEx.destAddr);
				checkWord(testName, "operandA", expOpA, idEx.operandA);
				checkWord(testName, "operandB", expOpB, idEx.operandB);
				checkBit(testName, "takenBranch", expTaken, idEx.takenBranch);
				checkBit(testName, "doWriteback", expWb, idEx.doWriteback);
				checkWord(testName, "nextPc", expNextPc, nextPc);
				if (expFlush)
					checkBit(testName, "idEx clear", 1'b1, idEx == '0);
				// aluOp add with no write only comes from a bubble
				if (expAluOp == 6'h00 && !expWb)
					checkBit(testName, "ctrl clear", 1'b1, idEx.ctrl == '0);
			end else begin
				$display("unknown line kind in the vector file: %s", line);
				stopWithFailure();
			end
		end
		finished = $feof(fd);
		$fclose(fd);

		if (!finished) begin
			$display("vector file did not finish within %0d cycles", maxCycles);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

// ==== dv/decode_input.txt ====
# W enable addr data
# D name instr pcNext freeze flush aluOp destAddr operandA operandB taken doWriteback nextPc
W 1 01 00000005
W 1 02 00000003
W 1 03 fffffff0
W 1 04 00000005
W 1 05 00001000
W 1 00 0000dead
D addu 00223021 00400004 0 0 37 06 00000005 00000003 0 1 00400004
D zeroReg 00013821 00400008 0 0 37 07 00000000 00000005 0 1 00400008
D sub 00224022 0040000c 0 0 1d 08 00000005 00000003 0 1 0040000c
D slt 0061482a 00400010 0 0 15 09 fffffff0 00000005 0 1 00400010
D sll 00025100 00400014 0 0 13 0a 00000000 00000003 0 1 00400014
D and 00225824 00400018 0 0 04 0b 00000005 00000003 0 1 00400018
D nor 00226027 0040001c 0 0 0f 0c 00000005 00000003 0 1 0040001c
D add 0022b020 00400040 0 0 00 16 00000005 00000003 0 1 00400040
D xor 0022b826 00400044 0 0 1f 17 00000005 00000003 0 1 00400044
D srav 0043c007 00400048 0 0 1a 18 00000003 fffffff0 0 1 00400048
D ori 342d8001 00400020 0 0 10 0d 00000005 00008001 0 1 00400020
D andi 3079ff00 0040004c 0 0 04 19 fffffff0 0000ff00 0 1 0040004c
D addi 206efff8 00400024 0 0 00 0e fffffff0 fffffff8 0 1 00400024
D lw 8caf0010 00400028 0 0 37 0f 00001000 00000010 0 1 00400028
D sw aca20008 0040002c 0 0 37 00 00001000 00000008 0 0 0040002c
D lui 3c101234 00400030 0 0 08 10 00000000 00001234 0 1 00400030
D beqTaken 10240004 00400100 0 0 3e 00 00000005 00000005 1 0 00400110
D bneNotTaken 14240004 00400200 0 0 3e 00 00000005 00000005 0 0 00400200
D blezTaken 1860fffc 00400300 0 0 3e 00 fffffff0 00000000 1 0 004002f0
D bgtzNotTaken 1c600008 00400400 0 0 3e 00 fffffff0 00000000 0 0 00400400
D bltzTaken 04600002 00400500 0 0 3e 00 fffffff0 00000000 1 0 00400508
D bgezNotTaken 04610002 00400600 0 0 3e 00 fffffff0 00000005 0 0 00400600
D j 08100040 00400704 0 0 3e 00 00000000 00000000 1 0 00400100
D jal 0c100080 00400804 0 0 37 1f 00400804 00000004 1 1 00400200
D jr 00a00008 00400904 0 0 3e 00 00001000 00000000 1 0 00001000
D jalr 00a0a009 00400a04 0 0 37 14 00400a04 00000004 1 1 00001000
D bltzalNotTaken 04300010 00400b04 0 0 37 1f 00400b04 00000004 0 1 00400b04
D bgezalTaken 04310010 00400c04 0 0 37 1f 00400c04 00000004 1 1 00400c44
D freezeHold 00223021 00400d00 1 0 37 1f 00400c04 00000004 1 1 00400c44
D flushBubble 00223021 00400e00 0 1 00 00 00000000 00000000 0 0 00400c44
D sltu 0061a82b 00400f00 0 0 3f 15 fffffff0 00000005 0 1 00400f00
D flushFreeze 00223021 00401000 1 1 00 00 00000000 00000000 0 0 00400f00
D unknownOp fc000000 00401100 0 0 00 00 00000000 00000000 0 0 00401100

// ==== flist.f ====
hw/decodePkg.sv
hw/controlDecoder.sv
hw/registerFile.sv
hw/branchUnit.sv
hw/idExRegister.sv
hw/decodeStage.sv
dv/decodeStage_props.sv
dv/decodeStage_tb.sv

// ==== hw/branchUnit.sv ====
/*
 * Branch unit
 * evaluates the branch compare and picks the next fetch address
 */
`timescale 1ns/1ps

module branchUnit (
	input  decodePkg::ctrl_t ctrl,
	input  decodePkg::word_t instr,
	input  decodePkg::word_t pcNext,
	input  decodePkg::word_t rsData,
	input  decodePkg::word_t rtData,
	output logic             takenBranch,
	output decodePkg::word_t fetchTarget
);
	import decodePkg::*;

	logic  condMet;
	word_t branchOffset;
	word_t jumpTarget;

	// --------------------------------------------------
	// signed compare for the zero tests
	// --------------------------------------------------
	always_comb begin
		case (ctrl.branchCond)
			condEq:     condMet = (rsData == rtData);
			condNe:     condMet = (rsData != rtData);
			condLez:    condMet = ($signed(rsData) <= 0);
			condGtz:    condMet = ($signed(rsData) > 0);
			condLtz:    condMet = ($signed(rsData) < 0);
			condGez:    condMet = ($signed(rsData) >= 0);
			condAlways: condMet = 1'b1;
			default:    condMet = 1'b0;
		endcase
	end

	assign takenBranch = (ctrl.jump | ctrl.branch) & condMet;

	// --------------------------------------------------
	// target selection
	// --------------------------------------------------
	assign branchOffset = {{(dataWidth-18){instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget   = {pcNext[dataWidth-1 -: 4], instr[25:0], 2'b00}; // same 256MB region

	always_comb begin
		if (ctrl.jumpReg)
			fetchTarget = rsData;
		else if (ctrl.jump)
			fetchTarget = jumpTarget;
		else if (ctrl.branch && condMet)
			fetchTarget = pcNext + branchOffset;
		else
			fetchTarget = pcNext;
	end

endmodule

// ==== hw/controlDecoder.sv ====
/*
 * Control decoder
 * turns an instruction word into the control bundle and destination register
 */
`timescale 1ns/1ps

module controlDecoder (
	input  decodePkg::word_t    instr,
	output decodePkg::ctrl_t    ctrl,
	output decodePkg::regAddr_t destAddr
);
	import decodePkg::*;

	opcode_t  opcode;
	funct_t   funct;
	regAddr_t rtField;

	assign opcode  = opcode_t'(instr[31:26]);
	assign funct   = funct_t'(instr[5:0]);
	assign rtField = instr[20:16];

	always_comb begin
		ctrl = '0; // unknown encodings stay a bubble
		case (opcode)
			opSpecial: begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					fnSll:  ctrl.aluOp = aluSll;
					fnSrl:  ctrl.aluOp = aluSrl;
					fnSra:  ctrl.aluOp = aluSra;
					fnSllv: ctrl.aluOp = aluSllv;
					fnSrlv: ctrl.aluOp = aluSrlv;
					fnSrav: ctrl.aluOp = aluSrav;
					fnAdd:  ctrl.aluOp = aluAdd;
					fnAddu: ctrl.aluOp = aluAddu;
					fnSub:  ctrl.aluOp = aluSub;
					fnSubu: ctrl.aluOp = aluSubu;
					fnAnd:  ctrl.aluOp = aluAnd;
					fnOr:   ctrl.aluOp = aluOr;
					fnXor:  ctrl.aluOp = aluXor;
					fnNor:  ctrl.aluOp = aluNor;
					fnSlt:  ctrl.aluOp = aluSlt;
					fnSltu: ctrl.aluOp = aluSltu;
					fnJr, fnJalr: begin
						ctrl.link       = funct[0];  // jalr links into rd
						ctrl.regDst     = funct[0];
						ctrl.regWrite   = funct[0];
						ctrl.jump       = 1'b1;
						ctrl.jumpReg    = 1'b1;
						ctrl.branchCond = condAlways;
						ctrl.aluOp      = funct[0] ? aluAddu : aluPassB;
					end
					default: ctrl = '0;
				endcase
			end
			opRegimm: begin
				ctrl.branch     = 1'b1;
				ctrl.branchCond = rtField[0] ? condGez : condLtz;
				ctrl.link       = rtField[4]; // bltzal, bgezal
				ctrl.regWrite   = rtField[4];
				ctrl.aluOp      = rtField[4] ? aluAddu : aluPassB;
				if (rtField[3:1] != 3'b000)
					ctrl = '0;
			end
			opJ, opJal: begin
				ctrl.jump       = 1'b1;
				ctrl.link       = instr[26]; // jal
				ctrl.regWrite   = instr[26];
				ctrl.branchCond = condAlways;
				ctrl.aluOp      = instr[26] ? aluAddu : aluPassB;
			end
			opBeq, opBne, opBlez, opBgtz: begin
				ctrl.branch     = 1'b1;
				ctrl.branchCond = branchCond_t'({1'b0, instr[27:26]});
				ctrl.aluOp      = aluPassB;
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				case (opcode)
					opAddi:  ctrl.aluOp = aluAdd;
					opAddiu: ctrl.aluOp = aluAddu;
					opSlti:  ctrl.aluOp = aluSlt;
					opSltiu: ctrl.aluOp = aluSltu;
					opAndi:  ctrl.aluOp = aluAnd;
					opOri:   ctrl.aluOp = aluOr;
					opXori:  ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluLui;
				endcase
			end
			opLw: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluAddu; // base plus offset
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAddu;
			end
			default: ctrl = '0;
		endcase
	end

	// rd for R-type, $31 for links, rt otherwise
	always_comb begin
		if (!ctrl.regWrite)
			destAddr = '0;
		else if (ctrl.regDst)
			destAddr = instr[15:11];
		else if (ctrl.link)
			destAddr = regAddr_t'(linkReg);
		else
			destAddr = rtField;
	end

endmodule

// ==== hw/decodePkg.sv ====
/*
 * Decode stage package
 * widths, opcode and ALU encodings, control and pipeline register structs
 */
package decodePkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int linkReg      = 31; // return address register
	localparam int linkOffset   = 4;  // added to pcNext by link instructions

	typedef logic [dataWidth-1:0]    word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// --------------------------------------------------
	// instruction encodings
	// --------------------------------------------------
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opBlez    = 6'h06,
		opBgtz    = 6'h07,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opSlti    = 6'h0A,
		opSltiu   = 6'h0B,
		opAndi    = 6'h0C,
		opOri     = 6'h0D,
		opXori    = 6'h0E,
		opLui     = 6'h0F,
		opLw      = 6'h23,
		opSw      = 6'h2B
	} opcode_t;

	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnSra  = 6'h03,
		fnSllv = 6'h04,
		fnSrlv = 6'h06,
		fnSrav = 6'h07,
		fnJr   = 6'h08,
		fnJalr = 6'h09,
		fnAdd  = 6'h20,
		fnAddu = 6'h21,
		fnSub  = 6'h22,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnNor  = 6'h27,
		fnSlt  = 6'h2A,
		fnSltu = 6'h2B
	} funct_t;

	// execute stage ALU codes
	typedef enum logic [5:0] {
		aluAdd   = 6'b000000,
		aluAddu  = 6'b110111,
		aluSub   = 6'b011101,
		aluSubu  = 6'b011110,
		aluAnd   = 6'b000100,
		aluOr    = 6'b010000,
		aluXor   = 6'b011111,
		aluNor   = 6'b001111,
		aluSlt   = 6'b010101,
		aluSltu  = 6'b111111,
		aluSll   = 6'b010011,
		aluSrl   = 6'b011011,
		aluSra   = 6'b011001,
		aluSllv  = 6'b010100,
		aluSrlv  = 6'b011100,
		aluSrav  = 6'b011010,
		aluLui   = 6'b001000,
		aluPassB = 6'b111110
	} aluOp_t;

	// low two bits of eq..gtz follow the opcode bits of BEQ..BGTZ
	typedef enum logic [2:0] {
		condEq     = 3'd0,
		condNe     = 3'd1,
		condLez    = 3'd2,
		condGtz    = 3'd3,
		condLtz    = 3'd4,
		condGez    = 3'd5,
		condAlways = 3'd6
	} branchCond_t;

	// --------------------------------------------------
	// bundles
	// --------------------------------------------------
	typedef struct packed {
		logic        link;
		logic        regDst;
		logic        jump;
		logic        jumpReg;
		logic        branch;
		logic        memRead;
		logic        memWrite;
		logic        memToReg;
		logic        aluSrc;
		logic        regWrite;
		branchCond_t branchCond;
		aluOp_t      aluOp;
	} ctrl_t;

	typedef struct packed {
		logic     enable;
		regAddr_t addr;
		word_t    data;
	} wbReq_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    operandA;
		word_t    operandB;
		word_t    storeData;
		regAddr_t rsAddr;
		regAddr_t rtAddr;
		regAddr_t destAddr;
		logic [4:0] shamt;
		word_t    imm;          // sign-extended immediate
		logic     takenBranch;
		logic     doWriteback;
	} idEx_t;

endpackage

// ==== hw/decodeStage.sv ====
/*
 * MIPS instruction decode stage
 * control decode, register read, branch resolve and the ID/EX register
 */
`timescale 1ns/1ps

module decodeStage (
	input  logic              CLK,
	input  logic              RESET,
	input  decodePkg::word_t  instr,
	input  decodePkg::word_t  pcNext,
	input  logic              freeze,
	input  logic              flush,
	input  decodePkg::wbReq_t wb,
	output decodePkg::idEx_t  idEx,
	output decodePkg::word_t  nextPc
);
	import decodePkg::*;

	ctrl_t    ctrl;
	regAddr_t destAddr;
	word_t    rsData;
	word_t    rtData;
	logic     takenBranch;
	word_t    fetchTarget;

	controlDecoder u_controlDecoder (
		.instr    (instr),
		.ctrl     (ctrl),
		.destAddr (destAddr)
	);

	registerFile u_registerFile (
		.CLK    (CLK),
		.RESET  (RESET),
		.rsAddr (instr[25:21]), // rs
		.rtAddr (instr[20:16]), // rt
		.rsData (rsData),
		.rtData (rtData),
		.wb     (wb)
	);

	branchUnit u_branchUnit (
		.ctrl        (ctrl),
		.instr       (instr),
		.pcNext      (pcNext),
		.rsData      (rsData),
		.rtData      (rtData),
		.takenBranch (takenBranch),
		.fetchTarget (fetchTarget)
	);

	idExRegister u_idExRegister (
		.CLK         (CLK),
		.RESET       (RESET),
		.freeze      (freeze),
		.flush       (flush),
		.instr       (instr),
		.pcNext      (pcNext),
		.ctrl        (ctrl),
		.destAddr    (destAddr),
		.rsData      (rsData),
		.rtData      (rtData),
		.takenBranch (takenBranch),
		.fetchTarget (fetchTarget),
		.idEx        (idEx),
		.nextPc      (nextPc)
	);

endmodule

// ==== hw/idExRegister.sv ====
/*
 * ID/EX pipeline register
 * forms the execute operands and holds them, with flush and freeze
 */
`timescale 1ns/1ps

module idExRegister (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                freeze,
	input  logic                flush,
	input  decodePkg::word_t    instr,
	input  decodePkg::word_t    pcNext,
	input  decodePkg::ctrl_t    ctrl,
	input  decodePkg::regAddr_t destAddr,
	input  decodePkg::word_t    rsData,
	input  decodePkg::word_t    rtData,
	input  logic                takenBranch,
	input  decodePkg::word_t    fetchTarget,
	output decodePkg::idEx_t    idEx,
	output decodePkg::word_t    nextPc
);
	import decodePkg::*;

	logic  zeroExt;
	word_t immSigned;
	word_t immAlu;
	idEx_t idExNext;

	// logical immediates are zero-extended
	assign zeroExt   = ctrl.aluSrc && (ctrl.aluOp inside {aluAnd, aluOr, aluXor});
	assign immSigned = {{16{instr[15]}}, instr[15:0]};
	assign immAlu    = zeroExt ? {16'b0, instr[15:0]} : immSigned;

	always_comb begin
		idExNext             = '0;
		idExNext.ctrl        = ctrl;
		idExNext.operandA    = ctrl.link ? pcNext : rsData;
		if (ctrl.link)
			idExNext.operandB = word_t'(linkOffset); // return address is pcNext + 4
		else if (ctrl.aluSrc)
			idExNext.operandB = immAlu;
		else
			idExNext.operandB = rtData;
		idExNext.storeData   = rtData;
		// only real sources keep an address for forwarding
		idExNext.rsAddr      = ctrl.link ? '0 : instr[25:21];
		idExNext.rtAddr      = (ctrl.link || (ctrl.aluSrc && !ctrl.memWrite)) ? '0 : instr[20:16];
		idExNext.destAddr    = destAddr;
		idExNext.shamt       = instr[10:6];
		idExNext.imm         = immSigned;
		idExNext.takenBranch = takenBranch;
		idExNext.doWriteback = ctrl.regWrite;
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			idEx   <= '0;
			nextPc <= '0;
		end else if (flush) begin
			idEx <= '0; // bubble with the fetch address kept
		end else if (!freeze) begin
			idEx   <= idExNext;
			nextPc <= fetchTarget;
		end
	end

endmodule

// ==== hw/registerFile.sv ====
/*
 * Integer register file
 * 32 words, two combinational reads, one write from writeback
 */
`timescale 1ns/1ps

module registerFile (
	input  logic                CLK,
	input  logic                RESET,
	input  decodePkg::regAddr_t rsAddr,
	input  decodePkg::regAddr_t rtAddr,
	output decodePkg::word_t    rsData,
	output decodePkg::word_t    rtData,
	input  decodePkg::wbReq_t   wb
);
	import decodePkg::*;

	word_t regs [2**regAddrWidth];

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end else if (wb.enable && wb.addr != '0) begin // $0 stays zero
			regs[wb.addr] <= wb.data;
		end
	end

	// no bypass so execute forwards
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

endmodule
